// File: source/dpath_pkg.sv
//------------------------------------------------------------
// Shared widths, encodings and control bundles for the scalar
// datapath. Imported by every datapath module that needs them.
//------------------------------------------------------------
package dpath_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0008_0000;

  //------------------------------------------------------------
  // Select and function encodings
  //------------------------------------------------------------

  typedef enum logic [1:0] {
    PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG
  } pc_sel_e;

  // Where a decode read value comes from
  typedef enum logic [1:0] {
    BYP_RF, BYP_X, BYP_M, BYP_W
  } byp_sel_e;

  typedef enum logic [1:0] {
    OP0_RS1, OP0_PC, OP0_PC4, OP0_ZERO
  } op0_sel_e;

  typedef enum logic [2:0] {
    OP1_RS2, OP1_SHAMT, OP1_IMM_U, OP1_IMM_SB, OP1_IMM_I, OP1_IMM_S, OP1_ZERO
  } op1_sel_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, OR, SLT, SLTU, AND, XOR, NOR, SRL, SRA
  } alu_fn_e;

  typedef enum logic [2:0] {
    LD_W, LD_B, LD_BU, LD_H, LD_HU
  } load_fn_e;

  //------------------------------------------------------------
  // Control and status bundles
  //------------------------------------------------------------

  typedef struct packed {
    op0_sel_e op0_sel;
    op1_sel_e op1_sel;
    byp_sel_e byp0_sel;
    byp_sel_e byp1_sel;
  } d_ctrl_t;

  typedef struct packed {
    load_fn_e load_fn;
    logic     queue_en;
    logic     queue_val;
    logic     wb_load;    // take the load result instead of the ALU result
  } m_ctrl_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
  } w_ctrl_t;

  // Per-stage hold levels
  typedef struct packed {
    logic f;
    logic d;
    logic x;
    logic m;
    logic w;
  } stall_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } branch_cond_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } dmem_req_t;

endpackage

// File: source/pc_fetch.sv
//------------------------------------------------------------
// Next-PC select, fetch PC register and PC+4. The selected PC
// goes out as the instruction address in the same cycle.
//------------------------------------------------------------
module pc_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  dpath_pkg::pc_sel_e      pc_sel,
  input  logic                    stall_f,
  input  logic [dpath_pkg::XLEN-1:0] branch_targ,
  input  logic [dpath_pkg::XLEN-1:0] jump_targ,
  input  logic [dpath_pkg::XLEN-1:0] jumpreg_targ,
  output logic [dpath_pkg::XLEN-1:0] imem_addr,
  output logic [dpath_pkg::XLEN-1:0] pc_f,
  output logic [dpath_pkg::XLEN-1:0] pc_plus4_f
);
  import dpath_pkg::*;

  logic [XLEN-1:0] pc_next;

  always_comb begin
    case (pc_sel)
      PC_BRANCH:  pc_next = branch_targ;
      PC_JUMP:    pc_next = jump_targ;
      PC_JUMPREG: pc_next = jumpreg_targ;
      default:    pc_next = pc_plus4_f;
    endcase
  end

  // Request goes out before the PC register captures it
  assign imem_addr = reset ? RESET_VECTOR : pc_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

endmodule

// File: source/operand_select.sv
//------------------------------------------------------------
// Decode-stage operand logic: immediates, jump and branch
// targets, read bypassing and the two ALU operand muxes.
//------------------------------------------------------------
module operand_select (
  input  logic [31:0]                     inst,
  input  logic [dpath_pkg::XLEN-1:0]      pc_d,
  input  logic [dpath_pkg::XLEN-1:0]      pc_plus4_d,
  input  dpath_pkg::d_ctrl_t              d_ctrl,
  input  logic [dpath_pkg::XLEN-1:0]      rf_rdata0,
  input  logic [dpath_pkg::XLEN-1:0]      rf_rdata1,
  input  logic [dpath_pkg::XLEN-1:0]      byp_x,
  input  logic [dpath_pkg::XLEN-1:0]      byp_m,
  input  logic [dpath_pkg::XLEN-1:0]      byp_w,
  output logic [dpath_pkg::REG_ADDR_W-1:0] rs1,
  output logic [dpath_pkg::REG_ADDR_W-1:0] rs2,
  output logic [dpath_pkg::XLEN-1:0]      op0,
  output logic [dpath_pkg::XLEN-1:0]      op1,
  output logic [dpath_pkg::XLEN-1:0]      wdata,
  output logic [dpath_pkg::XLEN-1:0]      branch_targ,
  output logic [dpath_pkg::XLEN-1:0]      jump_targ,
  output logic [dpath_pkg::XLEN-1:0]      jumpreg_targ
);
  import dpath_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_sb;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_uj;
  logic [XLEN-1:0] shamt;
  logic [XLEN-1:0] rdata0_byp;
  logic [XLEN-1:0] rdata1_byp;
  logic [XLEN-1:0] jumpreg_sum;

  // Both read ports share the same bypass choices
  function automatic logic [XLEN-1:0] byp_mux(
    input byp_sel_e        sel,
    input logic [XLEN-1:0] rf_val,
    input logic [XLEN-1:0] x_val,
    input logic [XLEN-1:0] m_val,
    input logic [XLEN-1:0] w_val
  );
    case (sel)
      BYP_X:   return x_val;
      BYP_M:   return m_val;
      BYP_W:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  //------------------------------------------------------------
  // Instruction fields
  //------------------------------------------------------------

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_sb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_uj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  // Shift amount sits in the rs2 field
  assign shamt  = {27'b0, inst[24:20]};

  //------------------------------------------------------------
  // Targets and operands
  //------------------------------------------------------------

  assign rdata0_byp = byp_mux(d_ctrl.byp0_sel, rf_rdata0, byp_x, byp_m, byp_w);
  assign rdata1_byp = byp_mux(d_ctrl.byp1_sel, rf_rdata1, byp_x, byp_m, byp_w);

  assign branch_targ  = pc_d + imm_sb;
  assign jump_targ    = pc_d + imm_uj;
  assign jumpreg_sum  = rdata0_byp + imm_i;
  assign jumpreg_targ = {jumpreg_sum[XLEN-1:1], 1'b0};

  always_comb begin
    case (d_ctrl.op0_sel)
      OP0_PC:   op0 = pc_d;
      OP0_PC4:  op0 = pc_plus4_d;
      OP0_ZERO: op0 = '0;
      default:  op0 = rdata0_byp;
    endcase
  end

  always_comb begin
    case (d_ctrl.op1_sel)
      OP1_RS2:    op1 = rdata1_byp;
      OP1_SHAMT:  op1 = shamt;
      OP1_IMM_U:  op1 = imm_u;
      OP1_IMM_SB: op1 = imm_sb;
      OP1_IMM_I:  op1 = imm_i;
      OP1_IMM_S:  op1 = imm_s;
      default:    op1 = '0;
    endcase
  end

  // Store data always comes from the second read port
  assign wdata = rdata1_byp;

endmodule

// File: source/regfile.sv
//------------------------------------------------------------
// Integer register file, 32 entries, two async reads and one
// clocked write. Register 0 reads as zero.
//------------------------------------------------------------
module regfile (
  input  logic                            clk,
  input  logic [dpath_pkg::REG_ADDR_W-1:0] raddr0,
  input  logic [dpath_pkg::REG_ADDR_W-1:0] raddr1,
  output logic [dpath_pkg::XLEN-1:0]       rdata0,
  output logic [dpath_pkg::XLEN-1:0]       rdata1,
  input  logic                            wen,
  input  logic [dpath_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [dpath_pkg::XLEN-1:0]       wdata
);

  logic [31:0] regs [32];

  // Entry 0 is never written
  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

endmodule

// File: source/alu.sv
//------------------------------------------------------------
// Execute-stage ALU with the branch condition flags. The flags
// are only meaningful while the function is SUB.
//------------------------------------------------------------
module alu (
  input  logic [dpath_pkg::XLEN-1:0] in0,
  input  logic [dpath_pkg::XLEN-1:0] in1,
  input  dpath_pkg::alu_fn_e         fn,
  output logic [dpath_pkg::XLEN-1:0] out,
  output dpath_pkg::branch_cond_t    branch_cond
);
  import dpath_pkg::*;

  logic [4:0] shamt;
  logic       diff_signs;

  assign shamt = in1[4:0];

  always_comb begin
    case (fn)
      ADD:     out = in0 + in1;
      SUB:     out = in0 - in1;
      SLL:     out = in0 << shamt;
      OR:      out = in0 | in1;
      SLT:     out = {31'b0, $signed(in0) < $signed(in1)};
      SLTU:    out = {31'b0, in0 < in1};
      AND:     out = in0 & in1;
      XOR:     out = in0 ^ in1;
      NOR:     out = ~(in0 | in1);
      SRL:     out = in0 >> shamt;
      SRA:     out = $signed(in0) >>> shamt;
      default: out = '0;
    endcase
  end

  //------------------------------------------------------------
  // Branch flags
  //------------------------------------------------------------

  // With equal signs the difference cannot overflow, so its sign decides
  assign diff_signs = in0[XLEN-1] ^ in1[XLEN-1];

  assign branch_cond.eq  = (out == '0);
  assign branch_cond.ne  = (out != '0);
  assign branch_cond.lt  = diff_signs ? in0[XLEN-1] : out[XLEN-1];
  assign branch_cond.ltu = diff_signs ? in1[XLEN-1] : out[XLEN-1];
  assign branch_cond.ge  = diff_signs ? in1[XLEN-1] : ~out[XLEN-1];
  assign branch_cond.geu = diff_signs ? in0[XLEN-1] : ~out[XLEN-1];

endmodule

// File: source/load_align.sv
//------------------------------------------------------------
// Memory-stage load path: subword extension of the response
// and a one-entry queue for responses used in a later cycle.
//------------------------------------------------------------
module load_align (
  input  logic                       clk,
  input  logic [31:0]                resp_data,
  input  dpath_pkg::load_fn_e        load_fn,
  input  logic                       queue_en,
  input  logic                       queue_val,
  output logic [dpath_pkg::XLEN-1:0] load_data
);
  import dpath_pkg::*;

  logic [XLEN-1:0] resp_adj;
  logic [XLEN-1:0] queue_q;

  always_comb begin
    case (load_fn)
      LD_B:    resp_adj = {{24{resp_data[7]}}, resp_data[7:0]};
      LD_BU:   resp_adj = {24'b0, resp_data[7:0]};
      LD_H:    resp_adj = {{16{resp_data[15]}}, resp_data[15:0]};
      LD_HU:   resp_adj = {16'b0, resp_data[15:0]};
      default: resp_adj = resp_data;
    endcase
  end

  // Holds the adjusted word, not the raw response
  always_ff @(posedge clk) begin
    if (queue_en) begin
      queue_q <= resp_adj;
    end
  end

  assign load_data = queue_val ? queue_q : resp_adj;

endmodule

// File: source/core_dpath.sv
//------------------------------------------------------------
// Scalar integer datapath, stages P F D X M W. Control, stalls
// and both memories sit outside and drive the ports per stage.
//------------------------------------------------------------
module core_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  dpath_pkg::pc_sel_e         pc_sel,
  input  logic [31:0]                inst,
  input  dpath_pkg::d_ctrl_t         d_ctrl,
  input  dpath_pkg::alu_fn_e         alu_fn,
  input  dpath_pkg::m_ctrl_t         m_ctrl,
  input  dpath_pkg::w_ctrl_t         w_ctrl,
  input  dpath_pkg::stall_t          stall,
  input  logic [31:0]                dmem_resp_data,
  output logic [dpath_pkg::XLEN-1:0] imem_addr,
  output dpath_pkg::dmem_req_t       dmem_req,
  output dpath_pkg::branch_cond_t    branch_cond,
  output logic [31:0]                csr_data
);
  import dpath_pkg::*;

  // Fetch
  logic [XLEN-1:0] pc_f;
  logic [XLEN-1:0] pc_plus4_f;

  // Decode
  logic [XLEN-1:0]       pc_d;
  logic [XLEN-1:0]       pc_plus4_d;
  logic [REG_ADDR_W-1:0] rs1_d;
  logic [REG_ADDR_W-1:0] rs2_d;
  logic [XLEN-1:0]       rf_rdata0_d;
  logic [XLEN-1:0]       rf_rdata1_d;
  logic [XLEN-1:0]       op0_d;
  logic [XLEN-1:0]       op1_d;
  logic [XLEN-1:0]       wdata_d;
  logic [XLEN-1:0]       branch_targ_d;
  logic [XLEN-1:0]       jump_targ_d;
  logic [XLEN-1:0]       jumpreg_targ_d;

  // Execute, memory, writeback
  logic [XLEN-1:0] op0_x;
  logic [XLEN-1:0] op1_x;
  logic [XLEN-1:0] wdata_x;
  logic [XLEN-1:0] branch_targ_x;
  logic [XLEN-1:0] alu_out_x;
  logic [XLEN-1:0] alu_out_m;
  logic [XLEN-1:0] load_data_m;
  logic [XLEN-1:0] wb_m;
  logic [XLEN-1:0] wb_w;

  pc_fetch u_pc_fetch (
    .clk          (clk),
    .reset        (reset),
    .pc_sel       (pc_sel),
    .stall_f      (stall.f),
    .branch_targ  (branch_targ_x),
    .jump_targ    (jump_targ_d),
    .jumpreg_targ (jumpreg_targ_d),
    .imem_addr    (imem_addr),
    .pc_f         (pc_f),
    .pc_plus4_f   (pc_plus4_f)
  );

  //------------------------------------------------------------
  // D <- F
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  regfile u_regfile (
    .clk    (clk),
    .raddr0 (rs1_d),
    .raddr1 (rs2_d),
    .rdata0 (rf_rdata0_d),
    .rdata1 (rf_rdata1_d),
    .wen    (w_ctrl.wen),
    .waddr  (w_ctrl.waddr),
    .wdata  (wb_w)
  );

  operand_select u_operand_select (
    .inst         (inst),
    .pc_d         (pc_d),
    .pc_plus4_d   (pc_plus4_d),
    .d_ctrl       (d_ctrl),
    .rf_rdata0    (rf_rdata0_d),
    .rf_rdata1    (rf_rdata1_d),
    .byp_x        (alu_out_x),
    .byp_m        (wb_m),
    .byp_w        (wb_w),
    .rs1          (rs1_d),
    .rs2          (rs2_d),
    .op0          (op0_d),
    .op1          (op1_d),
    .wdata        (wdata_d),
    .branch_targ  (branch_targ_d),
    .jump_targ    (jump_targ_d),
    .jumpreg_targ (jumpreg_targ_d)
  );

  //------------------------------------------------------------
  // X <- D
  //------------------------------------------------------------

  // Operands clear on reset so the flags settle to a known state
  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x <= '0;
      op1_x <= '0;
    end else if (!stall.x) begin
      op0_x <= op0_d;
      op1_x <= op1_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall.x) begin
      wdata_x       <= wdata_d;
      branch_targ_x <= branch_targ_d;
    end
  end

  alu u_alu (
    .in0         (op0_x),
    .in1         (op1_x),
    .fn          (alu_fn),
    .out         (alu_out_x),
    .branch_cond (branch_cond)
  );

  // Data request leaves in X, response comes back in M
  assign dmem_req.addr = alu_out_x;
  assign dmem_req.data = wdata_x;

  //------------------------------------------------------------
  // M <- X
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.m) begin
      alu_out_m <= alu_out_x;
    end
  end

  load_align u_load_align (
    .clk       (clk),
    .resp_data (dmem_resp_data),
    .load_fn   (m_ctrl.load_fn),
    .queue_en  (m_ctrl.queue_en),
    .queue_val (m_ctrl.queue_val),
    .load_data (load_data_m)
  );

  assign wb_m = m_ctrl.wb_load ? load_data_m : alu_out_m;

  //------------------------------------------------------------
  // W <- M
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_w <= '0;
    end else if (!stall.w) begin
      wb_w <= wb_m;
    end
  end

  assign csr_data = wb_w;

endmodule

// File: verification/core_dpath_checker.sv
//------------------------------------------------------------
// Port-level assertions for the datapath top level. Bound to
// every core_dpath instance by the bind at the end.
//------------------------------------------------------------
module core_dpath_checker (
  input logic                       clk,
  input logic                       reset,
  input dpath_pkg::pc_sel_e         pc_sel,
  input dpath_pkg::m_ctrl_t         m_ctrl,
  input dpath_pkg::stall_t          stall,
  input dpath_pkg::alu_fn_e         alu_fn,
  input logic [dpath_pkg::XLEN-1:0] imem_addr,
  input dpath_pkg::dmem_req_t       dmem_req,
  input dpath_pkg::branch_cond_t    branch_cond,
  input logic [31:0]                csr_data
);
  timeunit 1ns;
  timeprecision 100ps;

  import dpath_pkg::*;

  int unsigned fail_count = 0;

  // Fetch address
  a_reset_vector: assert property (@(posedge clk) reset |-> imem_addr == RESET_VECTOR)
    else begin
      fail_count++;
      $error("imem_addr is not the reset vector during reset");
    end

  a_pc_advance: assert property (@(posedge clk)
      $past(!stall.f && pc_sel == PC_PLUS4 && !reset) && pc_sel == PC_PLUS4 && !reset
      |-> imem_addr == $past(imem_addr) + 32'd4)
    else begin
      fail_count++;
      $error("imem_addr did not advance by 4");
    end

  a_pc_hold: assert property (@(posedge clk)
      $past(stall.f && pc_sel == PC_PLUS4 && !reset) && pc_sel == PC_PLUS4 && !reset
      |-> imem_addr == $past(imem_addr))
    else begin
      fail_count++;
      $error("imem_addr changed while fetch was stalled");
    end

  // State right after reset
  a_csr_reset: assert property (@(posedge clk) $past(reset) |-> csr_data == 32'd0)
    else begin
      fail_count++;
      $error("csr_data not cleared by reset");
    end

  a_flags_reset: assert property (@(posedge clk)
      $past(reset) && (alu_fn inside {ADD, SUB})
      |-> branch_cond.eq && branch_cond.ge && branch_cond.geu)
    else begin
      fail_count++;
      $error("branch flags wrong after reset");
    end

  //------------------------------------------------------------
  // ALU result into writeback
  //------------------------------------------------------------
  // X to M on one edge, M to W on the next
  a_alu_to_csr: assert property (@(posedge clk)
      !reset && $past(!stall.m, 2) && $past(!stall.w && !reset && !m_ctrl.wb_load)
      |-> csr_data == $past(dmem_req.addr, 2))
    else begin
      fail_count++;
      $error("ALU result did not reach csr_data two cycles later");
    end

endmodule

bind core_dpath core_dpath_checker u_checker (.*);

// File: verification/core_dpath_tb.sv
//------------------------------------------------------------
// Testbench for the datapath. Plays controller and memories
// with LFSR stimulus and checks every cycle against a model.
//------------------------------------------------------------
module core_dpath_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import dpath_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int FILL_CYCLES = 40;
  localparam int TEST_CYCLES = 600;
  localparam int TIMEOUT_NS = (RESET_CYCLES + FILL_CYCLES + TEST_CYCLES) * 4 + 200;

  logic clk;
  logic reset;
  pc_sel_e pc_sel;
  logic [31:0] inst;
  d_ctrl_t d_ctrl;
  alu_fn_e alu_fn;
  m_ctrl_t m_ctrl;
  w_ctrl_t w_ctrl;
  stall_t stall;
  logic [31:0] dmem_resp_data;
  logic [XLEN-1:0] imem_addr;
  dmem_req_t dmem_req;
  branch_cond_t branch_cond;
  logic [31:0] csr_data;

  // Model state
  logic [31:0] lfsr = 32'h2826_8767;
  logic [31:0] rf_m [32];
  logic [31:0] pc_f_m, pc_d_m, br_x_m, op0_x_m, op1_x_m, wdata_x_m, alu_m_m, wb_w_m, queue_m;
  logic queue_loaded = 1'b0;
  int errors = 0;

  core_dpath UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not finish in time");
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  //------------------------------------------------------------
  // Reference rules
  //------------------------------------------------------------
  function automatic logic [31:0] imm_i(logic [31:0] n);
    return {{20{n[31]}}, n[31:20]};
  endfunction

  function automatic logic [31:0] imm_sb(logic [31:0] n);
    return {{20{n[31]}}, n[7], n[30:25], n[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_uj(logic [31:0] n);
    return {{12{n[31]}}, n[19:12], n[20], n[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] op1_ref(op1_sel_e sel, logic [31:0] n, logic [31:0] rs2v);
    case (sel)
      OP1_RS2:    return rs2v;
      OP1_SHAMT:  return {27'd0, n[24:20]};
      OP1_IMM_U:  return {n[31:12], 12'd0};
      OP1_IMM_SB: return imm_sb(n);
      OP1_IMM_I:  return imm_i(n);
      OP1_IMM_S:  return {{20{n[31]}}, n[31:25], n[11:7]};
      default:    return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(alu_fn_e fn, logic [31:0] a, logic [31:0] b);
    case (fn)
      ADD:     return a + b;
      SUB:     return a - b;
      SLL:     return a << b[4:0];
      OR:      return a | b;
      SLT:     return {31'd0, $signed(a) < $signed(b)};
      SLTU:    return {31'd0, a < b};
      AND:     return a & b;
      XOR:     return a ^ b;
      NOR:     return ~(a | b);
      SRL:     return a >> b[4:0];
      SRA:     return $unsigned($signed(a) >>> b[4:0]);
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(load_fn_e fn, logic [31:0] d);
    case (fn)
      LD_B:    return {{24{d[7]}}, d[7:0]};
      LD_BU:   return {24'd0, d[7:0]};
      LD_H:    return {{16{d[15]}}, d[15:0]};
      LD_HU:   return {16'd0, d[15:0]};
      default: return d;
    endcase
  endfunction

  function automatic logic [31:0] wb_m_ref();
    if (!m_ctrl.wb_load) return alu_m_m;
    return m_ctrl.queue_val ? queue_m : load_ref(m_ctrl.load_fn, dmem_resp_data);
  endfunction

  function automatic logic [31:0] rd_ref(byp_sel_e sel, logic [4:0] idx);
    case (sel)
      BYP_X:   return alu_ref(alu_fn, op0_x_m, op1_x_m);
      BYP_M:   return wb_m_ref();
      BYP_W:   return wb_w_m;
      default: return rf_m[idx];
    endcase
  endfunction

  function automatic logic [31:0] pc_ref();
    if (reset) return RESET_VECTOR;
    case (pc_sel)
      PC_BRANCH: return br_x_m;
      PC_JUMP:   return pc_d_m + imm_uj(inst);
      PC_JUMPREG: return (rd_ref(d_ctrl.byp0_sel, inst[19:15]) + imm_i(inst)) & ~32'd1;
      default:   return pc_f_m + 32'd4;
    endcase
  endfunction

  //------------------------------------------------------------
  // Stimulus, model update and checks
  //------------------------------------------------------------
  task automatic drive_inputs(bit fill, logic [4:0] fill_addr);
    logic [31:0] r;
    inst = rand_bits(32);
    dmem_resp_data = rand_bits(32);
    r = rand_bits(3);
    pc_sel = fill ? PC_PLUS4 : pc_sel_e'(r[1:0]);
    stall.f = r[2];
    // Later stages hold about one cycle in four
    r = rand_bits(8);
    stall.d = r[0] & r[1];
    stall.x = r[2] & r[3];
    stall.m = r[4] & r[5];
    stall.w = r[6] & r[7];
    r = rand_bits(9);
    d_ctrl.op0_sel = op0_sel_e'(r[1:0]);
    d_ctrl.op1_sel = op1_sel_e'((r[4:2] == 3'd7) ? 3'd6 : r[4:2]);
    // Register file still unknown while filling
    d_ctrl.byp0_sel = byp_sel_e'((fill && r[6:5] == 2'd0) ? 2'd3 : r[6:5]);
    d_ctrl.byp1_sel = byp_sel_e'((fill && r[8:7] == 2'd0) ? 2'd3 : r[8:7]);
    r = rand_bits(4);
    alu_fn = alu_fn_e'(r[3:0] % 4'd11);
    r = rand_bits(6);
    m_ctrl.load_fn = load_fn_e'(r[2:0] % 3'd5);
    m_ctrl.queue_en = r[3];
    m_ctrl.queue_val = r[4] && queue_loaded;
    m_ctrl.wb_load = r[5];
    r = rand_bits(6);
    w_ctrl.wen = fill | r[5];
    w_ctrl.waddr = fill ? fill_addr : r[4:0];
  endtask

  task automatic note_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic check_outputs();
    logic [31:0] alu_x;
    branch_cond_t exp_bc;
    alu_x = alu_ref(alu_fn, op0_x_m, op1_x_m);
    exp_bc.eq = (op0_x_m == op1_x_m);
    exp_bc.ne = !exp_bc.eq;
    exp_bc.lt = $signed(op0_x_m) < $signed(op1_x_m);
    exp_bc.ltu = op0_x_m < op1_x_m;
    exp_bc.ge = !exp_bc.lt;
    exp_bc.geu = !exp_bc.ltu;
    assert (imem_addr === pc_ref()) else note_mismatch("imem_addr", imem_addr, pc_ref());
    assert (dmem_req.addr === alu_x) else note_mismatch("dmem_req.addr", dmem_req.addr, alu_x);
    assert (dmem_req.data === wdata_x_m)
      else note_mismatch("dmem_req.data", dmem_req.data, wdata_x_m);
    assert (csr_data === wb_w_m) else note_mismatch("csr_data", csr_data, wb_w_m);
    if (alu_fn == SUB) begin
      assert (branch_cond === exp_bc)
        else note_mismatch("branch_cond", {26'd0, branch_cond}, {26'd0, exp_bc});
    end
  endtask

  // Samples the pre-edge values, then applies the register updates
  task automatic advance_model();
    logic [31:0] alu_x, wb_m, ld_adj, npc, r0, r1, op0_n, op1_n;
    alu_x = alu_ref(alu_fn, op0_x_m, op1_x_m);
    ld_adj = load_ref(m_ctrl.load_fn, dmem_resp_data);
    wb_m = wb_m_ref();
    npc = pc_ref();
    r0 = rd_ref(d_ctrl.byp0_sel, inst[19:15]);
    r1 = rd_ref(d_ctrl.byp1_sel, inst[24:20]);
    case (d_ctrl.op0_sel)
      OP0_PC:   op0_n = pc_d_m;
      OP0_PC4:  op0_n = pc_d_m + 32'd4;
      OP0_ZERO: op0_n = 32'd0;
      default:  op0_n = r0;
    endcase
    op1_n = op1_ref(d_ctrl.op1_sel, inst, r1);
    @(posedge clk);
    if (w_ctrl.wen && w_ctrl.waddr != 5'd0) rf_m[w_ctrl.waddr] = wb_w_m;
    if (reset) wb_w_m = 32'd0;
    else if (!stall.w) wb_w_m = wb_m;
    if (!stall.m) alu_m_m = alu_x;
    if (m_ctrl.queue_en) begin
      queue_m = ld_adj;
      queue_loaded = 1'b1;
    end
    if (reset) begin
      op0_x_m = 32'd0;
      op1_x_m = 32'd0;
    end else if (!stall.x) begin
      op0_x_m = op0_n;
      op1_x_m = op1_n;
    end
    if (!stall.x) begin
      wdata_x_m = r1;
      br_x_m = pc_d_m + imm_sb(inst);
    end
    if (!stall.d) pc_d_m = pc_f_m;
    if (reset) pc_f_m = RESET_VECTOR;
    else if (!stall.f) pc_f_m = npc;
  endtask

  initial begin
    int total;
    for (int i = 0; i < 32; i++) rf_m[i] = 32'd0;
    {pc_f_m, pc_d_m, br_x_m, op0_x_m, op1_x_m} = '0;
    {wdata_x_m, alu_m_m, wb_w_m, queue_m} = '0;
    reset = 1'b1;
    pc_sel = PC_PLUS4;
    inst = 32'd0;
    d_ctrl = '0;
    alu_fn = ADD;
    m_ctrl = '0;
    w_ctrl = '0;
    stall = '0;
    dmem_resp_data = 32'd0;
    total = RESET_CYCLES + FILL_CYCLES + TEST_CYCLES;
    for (int cyc = 0; cyc < total; cyc++) begin
      if (cyc == RESET_CYCLES) reset = 1'b0;
      if (!reset) drive_inputs(cyc < RESET_CYCLES + FILL_CYCLES, cyc[4:0]);
      @(negedge clk);
      if (!reset) check_outputs();
      else if (imem_addr !== RESET_VECTOR) note_mismatch("imem_addr", imem_addr, RESET_VECTOR);
      advance_model();
      #1;
    end
    $display("Closing report: %0d testbench errors, %0d assertion errors",
             errors, UUT.u_checker.fail_count);
    if (errors == 0 && UUT.u_checker.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: list.f
source/dpath_pkg.sv
source/pc_fetch.sv
source/operand_select.sv
source/regfile.sv
source/alu.sv
source/load_align.sv
source/core_dpath.sv
verification/core_dpath_checker.sv
verification/core_dpath_tb.sv

// File: Makefile
VERILATOR = verilator
TOP       = core_dpath_tb
FILELIST  = list.f
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
